// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    localparam int REG_W  = 4;     // Register index width
    localparam int DATA_W = 32;
    localparam int OP_W   = 5;

    // Opcodes that leave the destination register untouched
    localparam logic [OP_W-1:0] OP_NOP     = 5'h00;
    localparam logic [OP_W-1:0] OP_NOWRITE = 5'h0C;

    // Decoded instruction of 82 bits from the decode stage
    typedef struct packed {
        logic [OP_W-1:0]   opcode;
        logic              ri;      // 1 selects imm32 for the second operand
        logic [REG_W-1:0]  dr;
        logic [REG_W-1:0]  sr1;
        logic [REG_W-1:0]  sr2;
        logic [DATA_W-1:0] imm32;
        logic [DATA_W-1:0] pc;
    } issue_t;

    // Register/value pair for forwarding and writeback
    typedef struct packed {
        logic [REG_W-1:0]  reg_idx; // Zero when the pair is empty
        logic [DATA_W-1:0] data;
    } fwd_t;

    // Stage buffer contents
    // sr1/sr2 stay nonzero only while that operand is unresolved
    typedef struct packed {
        logic [OP_W-1:0]   opcode;
        logic [REG_W-1:0]  dr;
        logic [REG_W-1:0]  sr1;
        logic [REG_W-1:0]  sr2;
        logic [DATA_W-1:0] sr1_val;
        logic [DATA_W-1:0] sr2_val;
        logic [DATA_W-1:0] pc;
    } rr_out_t;

endpackage

// ==== design/reg_file.sv ====
module reg_file import cpu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic                i_clk,
    input  logic                i_reset,

    // Combinational read ports
    input  logic [REG_W-1:0]    i_read_a1,
    input  logic [REG_W-1:0]    i_read_a2,
    output logic [DATA_W-1:0]   o_read_d1,
    output logic [DATA_W-1:0]   o_read_d2,

    input  logic [REG_W-1:0]    i_set_busy,  // Zero means no register
    input  fwd_t                i_wb,        // Writeback clears the busy bit
    output logic [NUM_REGS-2:0] o_busy       // Bit n-1 belongs to rn
);

    // r0 has no storage
    logic [DATA_W-1:0]   regs [1:NUM_REGS-1];
    logic [NUM_REGS-2:0] busy;

    assign o_busy = busy;

    // Reads see the value from before a same-cycle writeback
    always_comb begin
        o_read_d1 = '0;
        o_read_d2 = '0;
        if ((i_read_a1 != '0) && (i_read_a1 < NUM_REGS))
            o_read_d1 = regs[i_read_a1];
        if ((i_read_a2 != '0) && (i_read_a2 < NUM_REGS))
            o_read_d2 = regs[i_read_a2];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int r = 1; r < NUM_REGS; r++)
                regs[r] <= '0;
            busy <= '0;
        end else begin
            if (i_wb.reg_idx != '0) begin
                regs[i_wb.reg_idx]        <= i_wb.data;
                busy[i_wb.reg_idx - 1'b1] <= 1'b0;
            end
            // A new owner beats the writeback clear
            if (i_set_busy != '0)
                busy[i_set_busy - 1'b1] <= 1'b1;
        end
    end

    // Nothing may be marked busy coming out of reset
    a_busy_clear_after_reset: assert property (
        @(posedge i_clk) i_reset |=> (o_busy == '0)
    ) else $error("busy list not clear after reset");

endmodule

// ==== design/operand_resolve.sv ====
module operand_resolve import cpu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic [REG_W-1:0]    i_src,
    input  logic                i_use_imm,
    input  logic [DATA_W-1:0]   i_imm,
    input  logic [DATA_W-1:0]   i_reg_data,  // Register file read data
    input  logic [NUM_REGS-2:0] i_busy,
    input  fwd_t                i_fwd1,
    input  fwd_t                i_fwd2,
    output logic [DATA_W-1:0]   o_val,
    output logic [REG_W-1:0]    o_pending    // Nonzero while unresolved
);

    logic src_busy;

    // r0 is never busy
    assign src_busy = (i_src != '0) && i_busy[i_src - 1'b1];

    always_comb begin
        o_val     = '0;
        o_pending = '0;
        if (i_use_imm)
            o_val = i_imm;
        else if (!src_busy)
            o_val = i_reg_data;
        else if (i_fwd1.reg_idx == i_src)   // Bus 1 has priority
            o_val = i_fwd1.data;
        else if (i_fwd2.reg_idx == i_src)
            o_val = i_fwd2.data;
        else
            o_pending = i_src;              // Later stage waits on this one
    end

endmodule

// ==== design/reg_read_stage.sv ====
module reg_read_stage import cpu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic                i_clk,
    input  logic                i_reset,

    input  issue_t              i_issue,
    input  fwd_t                i_fwd1,
    input  fwd_t                i_fwd2,

    input  logic                i_pipe_stall,
    input  logic                i_pipe_flush,
    output logic                o_pipe_stall,
    output logic                o_pipe_flush,

    // Register file side
    output logic [REG_W-1:0]    o_read_a1,
    output logic [REG_W-1:0]    o_read_a2,
    input  logic [DATA_W-1:0]   i_read_d1,
    input  logic [DATA_W-1:0]   i_read_d2,
    input  logic [NUM_REGS-2:0] i_busy,
    output logic [REG_W-1:0]    o_set_busy,

    output rr_out_t             o_rr        // Stage buffer
);

    logic              no_dest;
    logic              sr1_use_imm;
    logic [DATA_W-1:0] sr1_val;
    logic [DATA_W-1:0] sr2_val;
    logic [REG_W-1:0]  sr1_pending;
    logic [REG_W-1:0]  sr2_pending;
    rr_out_t           rr_next;

    // This stage never raises stall or flush itself
    assign o_pipe_stall = i_pipe_stall;
    assign o_pipe_flush = i_pipe_flush;

    assign o_read_a1 = i_issue.sr1;
    assign o_read_a2 = i_issue.sr2;

    // Mark the destination busy as the instruction is issued
    assign no_dest    = (i_issue.opcode == OP_NOP) || (i_issue.opcode == OP_NOWRITE);
    assign o_set_busy = (i_pipe_stall || no_dest) ? '0 : i_issue.dr;

    // Only the second operand has an immediate form
    assign sr1_use_imm = 1'b0;

    operand_resolve #(
        .NUM_REGS  (NUM_REGS)
    ) u_resolve_sr1 (
        .i_src      (i_issue.sr1),
        .i_use_imm  (sr1_use_imm),
        .i_imm      (i_issue.imm32),
        .i_reg_data (i_read_d1),
        .i_busy     (i_busy),
        .i_fwd1     (i_fwd1),
        .i_fwd2     (i_fwd2),
        .o_val      (sr1_val),
        .o_pending  (sr1_pending)
    );

    operand_resolve #(
        .NUM_REGS  (NUM_REGS)
    ) u_resolve_sr2 (
        .i_src      (i_issue.sr2),
        .i_use_imm  (i_issue.ri),
        .i_imm      (i_issue.imm32),
        .i_reg_data (i_read_d2),
        .i_busy     (i_busy),
        .i_fwd1     (i_fwd1),
        .i_fwd2     (i_fwd2),
        .o_val      (sr2_val),
        .o_pending  (sr2_pending)
    );

    always_comb begin
        rr_next.opcode  = i_issue.opcode;
        rr_next.dr      = i_issue.dr;
        rr_next.sr1     = sr1_pending;
        rr_next.sr2     = sr2_pending;
        rr_next.sr1_val = sr1_val;
        rr_next.sr2_val = sr2_val;
        rr_next.pc      = i_issue.pc;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_pipe_flush)
            o_rr <= '0;         // Flushed slot becomes a no-op
        else if (!i_pipe_stall)
            o_rr <= rr_next;
    end

    a_flush_gives_nop: assert property (
        @(posedge i_clk) i_pipe_flush |=> (o_rr.opcode == OP_NOP)
    ) else $error("opcode not cleared after flush");

    a_stall_holds_buffer: assert property (
        @(posedge i_clk) (i_pipe_stall && !i_pipe_flush && !i_reset) |=> $stable(o_rr)
    ) else $error("stage buffer changed during stall");

endmodule

// ==== design/reg_read_top.sv ====
module reg_read_top import cpu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic    i_clk,
    input  logic    i_reset,

    input  issue_t  i_issue,
    input  fwd_t    i_fwd1,
    input  fwd_t    i_fwd2,
    input  fwd_t    i_wb,

    input  logic    i_pipe_stall,
    input  logic    i_pipe_flush,

    output rr_out_t o_rr,
    output logic    o_pipe_stall,
    output logic    o_pipe_flush
);

    logic [REG_W-1:0]    read_a1;
    logic [REG_W-1:0]    read_a2;
    logic [DATA_W-1:0]   read_d1;
    logic [DATA_W-1:0]   read_d2;
    logic [REG_W-1:0]    set_busy;
    logic [NUM_REGS-2:0] busy;

    reg_read_stage #(
        .NUM_REGS     (NUM_REGS)
    ) u_stage (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_issue      (i_issue),
        .i_fwd1       (i_fwd1),
        .i_fwd2       (i_fwd2),
        .i_pipe_stall (i_pipe_stall),
        .i_pipe_flush (i_pipe_flush),
        .o_pipe_stall (o_pipe_stall),
        .o_pipe_flush (o_pipe_flush),
        .o_read_a1    (read_a1),
        .o_read_a2    (read_a2),
        .i_read_d1    (read_d1),
        .i_read_d2    (read_d2),
        .i_busy       (busy),
        .o_set_busy   (set_busy),
        .o_rr         (o_rr)
    );

    reg_file #(
        .NUM_REGS   (NUM_REGS)
    ) u_reg_file (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_read_a1  (read_a1),
        .i_read_a2  (read_a2),
        .o_read_d1  (read_d1),
        .o_read_d2  (read_d2),
        .i_set_busy (set_busy),
        .i_wb       (i_wb),
        .o_busy     (busy)
    );

endmodule

// ==== bench/reg_read_tb.sv ====
module reg_read_tb import cpu_pkg::*; ();

    localparam int    NUM_REGS     = 16;
    localparam int    CLK_HALF     = 50;
    localparam int    RESET_CYCLES = 5;
    localparam int    EXTRA_CYCLES = 20;    // Margin over the vector count
    localparam int    NUM_FIELDS   = 24;    // Name plus 23 hex columns
    localparam string INPUT_FILE   = "bench/reg_read_input.txt";

    // One line of the vector file
    typedef struct packed {
        logic [8*16-1:0] name;
        issue_t          issue;
        fwd_t            fwd1;
        fwd_t            fwd2;
        fwd_t            wb;
        logic            stall;
        logic            flush;
        logic            check_en;
        rr_out_t         exp_rr;
    } vector_t;

    logic    clk;
    logic    reset;
    issue_t  issue;
    fwd_t    fwd1;
    fwd_t    fwd2;
    fwd_t    wb;
    logic    pipe_stall;
    logic    pipe_flush;
    rr_out_t rr;
    logic    stall_out;
    logic    flush_out;

    vector_t vectors[$];
    int      cycle_count = 0;
    int      cycle_limit = 0;

    reg_read_top #(
        .NUM_REGS     (NUM_REGS)
    ) UUT (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_issue      (issue),
        .i_fwd1       (fwd1),
        .i_fwd2       (fwd2),
        .i_wb         (wb),
        .i_pipe_stall (pipe_stall),
        .i_pipe_flush (pipe_flush),
        .o_rr         (rr),
        .o_pipe_stall (stall_out),
        .o_pipe_flush (flush_out)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    // Guards against a run that never reaches the end of the vectors
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_rr(input logic [8*16-1:0] name, input rr_out_t exp_rr,
                            input rr_out_t act_rr);
        if (act_rr !== exp_rr) begin
            $display("** Error %0s: expected %h actual %h", name, exp_rr, act_rr);
            $display("   expected op %h dr %h sr1 %h sr2 %h v1 %h v2 %h pc %h",
                     exp_rr.opcode, exp_rr.dr, exp_rr.sr1, exp_rr.sr2,
                     exp_rr.sr1_val, exp_rr.sr2_val, exp_rr.pc);
            $display("   actual   op %h dr %h sr1 %h sr2 %h v1 %h v2 %h pc %h",
                     act_rr.opcode, act_rr.dr, act_rr.sr1, act_rr.sr2,
                     act_rr.sr1_val, act_rr.sr2_val, act_rr.pc);
            abort_run();
        end
    endtask

    task automatic check_level(input logic [8*16-1:0] name, input string sig,
                               input logic exp_lvl, input logic act_lvl);
        if (act_lvl !== exp_lvl) begin
            $display("** Error %0s %0s: expected %b actual %b", name, sig, exp_lvl, act_lvl);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              n;
        string           line;
        logic [8*16-1:0] name_buf;
        logic [31:0]     f [0:22];
        vector_t         v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %0s", INPUT_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if ((line.len() == 0) || (line.getc(0) == "#"))
                continue;                       // Column notes
            n = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name_buf, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                        f[18], f[19], f[20], f[21], f[22]);
            if (n <= 0)
                continue;                       // Blank line
            if (n != NUM_FIELDS) begin
                $display("Vector line has %0d fields instead of %0d: %0s", n, NUM_FIELDS, line);
                abort_run();
            end
            v.name          = name_buf;
            v.issue.opcode  = f[0][OP_W-1:0];
            v.issue.ri      = f[1][0];
            v.issue.dr      = f[2][REG_W-1:0];
            v.issue.sr1     = f[3][REG_W-1:0];
            v.issue.sr2     = f[4][REG_W-1:0];
            v.issue.imm32   = f[5];
            v.issue.pc      = f[6];
            v.fwd1.reg_idx  = f[7][REG_W-1:0];
            v.fwd1.data     = f[8];
            v.fwd2.reg_idx  = f[9][REG_W-1:0];
            v.fwd2.data     = f[10];
            v.wb.reg_idx    = f[11][REG_W-1:0];
            v.wb.data       = f[12];
            v.stall         = f[13][0];
            v.flush         = f[14][0];
            v.check_en      = f[15][0];
            v.exp_rr.opcode  = f[16][OP_W-1:0];
            v.exp_rr.dr      = f[17][REG_W-1:0];
            v.exp_rr.sr1     = f[18][REG_W-1:0];
            v.exp_rr.sr2     = f[19][REG_W-1:0];
            v.exp_rr.sr1_val = f[20];
            v.exp_rr.sr2_val = f[21];
            v.exp_rr.pc      = f[22];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The vector file %0s holds no vectors", INPUT_FILE);
            abort_run();
        end
    endtask

    initial begin
        issue      = '0;
        fwd1       = '0;
        fwd2       = '0;
        wb         = '0;
        pipe_stall = 1'b0;
        pipe_flush = 1'b0;
        reset      = 1'b1;
        load_vectors();
        cycle_limit = RESET_CYCLES + vectors.size() + EXTRA_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (vectors[i]) begin
            issue      = vectors[i].issue;      // Applied on the falling edge
            fwd1       = vectors[i].fwd1;
            fwd2       = vectors[i].fwd2;
            wb         = vectors[i].wb;
            pipe_stall = vectors[i].stall;
            pipe_flush = vectors[i].flush;
            @(negedge clk);
            check_level(vectors[i].name, "o_pipe_stall", vectors[i].stall, stall_out);
            check_level(vectors[i].name, "o_pipe_flush", vectors[i].flush, flush_out);
            if (vectors[i].check_en)
                check_rr(vectors[i].name, vectors[i].exp_rr, rr);
        end
        $display("No errors");
        $finish;
    end

endmodule

// ==== bench/reg_read_input.txt ====
# name | op ri dr sr1 sr2 imm32 pc | fwd1 reg data | fwd2 reg data | wb reg data | stall flush chk
# expected o_rr after the next rising edge: op dr sr1 sr2 sr1_val sr2_val pc (all hex)
wb_r1     0 0 0 0 0 0 0    0 0 0 0 1 11      0 0 1  0 0 0 0 0 0 0
wb_r2     0 0 0 0 0 0 0    0 0 0 0 2 22      0 0 1  0 0 0 0 0 0 0
wb_r3     0 0 0 0 0 0 0    0 0 0 0 3 33      0 0 1  0 0 0 0 0 0 0
wb_r5     0 0 0 0 0 0 0    0 0 0 0 5 55      0 0 1  0 0 0 0 0 0 0
rd_r1r2   1 0 4 1 2 0 100  0 0 0 0 0 0       0 0 1  1 4 0 0 11 22 100
rd_r0r3   2 0 0 0 3 0 104  0 0 0 0 0 0       0 0 1  2 0 0 0 0 33 104
fwd1_r4   1 0 6 4 1 0 108  4 44 0 0 0 0      0 0 1  1 6 0 0 44 11 108
fwd2_r6   3 0 7 6 4 0 10c  2 99 6 66 0 0     0 0 1  3 7 0 4 66 0 10c
fwd_both  1 0 8 7 5 0 110  7 71 7 72 0 0     0 0 1  1 8 0 0 71 55 110
pend_2    1 0 9 8 6 0 114  0 0 0 0 0 0       0 0 1  1 9 8 6 0 0 114
imm_busy  5 1 a 1 4 12345678 118  0 0 0 0 0 0  0 0 1  5 a 0 0 11 12345678 118
nop_dr    0 0 b 2 3 0 11c  0 0 0 0 b bb      0 0 1  0 b 0 0 22 33 11c
nowr_dr   c 0 c 1 2 0 120  0 0 0 0 c cc      0 0 1  c c 0 0 11 22 120
rd_bc     1 0 0 b c 0 124  0 0 0 0 0 0       0 0 1  1 0 0 0 bb cc 124
wb_r4     0 0 0 0 0 0 0    0 0 0 0 4 444     0 0 1  0 0 0 0 0 0 0
rd_r4     1 0 0 4 6 0 128  0 0 0 0 0 0       0 0 1  1 0 0 6 444 0 128
set_win   1 0 5 0 0 0 12c  0 0 0 0 5 555     0 0 1  1 5 0 0 0 0 12c
rd_r5     1 0 0 5 5 0 130  0 0 5 5f5 0 0     0 0 1  1 0 0 0 5f5 5f5 130
wb_old    1 0 0 1 2 0 134  0 0 0 0 1 1111    0 0 1  1 0 0 0 11 22 134
load      1 0 0 1 3 0 138  0 0 0 0 0 0       0 0 1  1 0 0 0 1111 33 138
stall_1   2 0 d 2 2 0 13c  0 0 0 0 0 0       1 0 1  1 0 0 0 1111 33 138
stall_2   2 0 d 2 2 0 13c  0 0 0 0 d dd      1 0 1  1 0 0 0 1111 33 138
unstall   1 0 0 d 0 0 140  0 0 0 0 0 0       0 0 1  1 0 0 0 dd 0 140
flush     1 0 0 1 2 0 144  0 0 0 0 0 0       0 1 1  0 0 0 0 0 0 0
reload    3 0 0 1 2 0 148  0 0 0 0 0 0       0 0 1  3 0 0 0 1111 22 148
st_fl     3 0 0 1 2 0 148  0 0 0 0 0 0       1 1 1  0 0 0 0 0 0 0
skip      0 0 0 0 0 0 0    0 0 0 0 0 0       0 0 0  0 0 0 0 0 0 0
idle      0 0 0 0 0 0 0    0 0 0 0 0 0       0 0 1  0 0 0 0 0 0 0

// ==== files.f ====
design/cpu_pkg.sv
design/reg_file.sv
design/operand_resolve.sv
design/reg_read_stage.sv
design/reg_read_top.sv
bench/reg_read_tb.sv

// ==== Makefile ====
# Verilator build for the register-read stage testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= reg_read_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(SIM_BIN) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)
